// File: include/ctrl_config.svh
// widths, opcode values and the bubble word of the control path; include before use
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// datapath and field widths
`define CTRL_XLEN      32
`define CTRL_REG_AW    5
`define CTRL_OPC_W     6

// nop opcode with bit 16 set marks a bubble
`define CTRL_NOP_WORD  32'h1541_0000
// jal and jalr write the return address here
`define CTRL_LINK_REG  5'd9

////////////////////////////////////////////////////////////////////////////
// major opcodes, instruction bits 31:26
////////////////////////////////////////////////////////////////////////////
`define CTRL_OPC_J        6'h00
`define CTRL_OPC_JAL      6'h01
`define CTRL_OPC_BNF      6'h03
`define CTRL_OPC_BF       6'h04
`define CTRL_OPC_NOP      6'h05
`define CTRL_OPC_MOVHI    6'h06
`define CTRL_OPC_XSYNC    6'h08
`define CTRL_OPC_RFE      6'h09
`define CTRL_OPC_JR       6'h11
`define CTRL_OPC_JALR     6'h12
`define CTRL_OPC_LWZ      6'h21
`define CTRL_OPC_LWS      6'h22
`define CTRL_OPC_LBZ      6'h23
`define CTRL_OPC_LBS      6'h24
`define CTRL_OPC_LHZ      6'h25
`define CTRL_OPC_LHS      6'h26
`define CTRL_OPC_ADDI     6'h27
`define CTRL_OPC_ADDIC    6'h28
`define CTRL_OPC_ANDI     6'h29
`define CTRL_OPC_ORI      6'h2a
`define CTRL_OPC_XORI     6'h2b
`define CTRL_OPC_MFSPR    6'h2d
`define CTRL_OPC_SH_ROTI  6'h2e
`define CTRL_OPC_SFXXI    6'h2f
`define CTRL_OPC_MTSPR    6'h30
`define CTRL_OPC_SW       6'h35
`define CTRL_OPC_SB       6'h36
`define CTRL_OPC_SH       6'h37
`define CTRL_OPC_ALU      6'h38
`define CTRL_OPC_SFXX     6'h39

`endif

// File: source/ctrl_pkg.sv
// instruction formats and operation encodings shared by every control path stage
`include "ctrl_config.svh"

package ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// instruction word views
	////////////////////////////////////////////////////////////////////////////

	// immediate form, also used for jumps and branches
	typedef struct packed {
		logic [`CTRL_OPC_W-1:0]  opcode;
		logic [`CTRL_REG_AW-1:0] rd;
		logic [`CTRL_REG_AW-1:0] ra;
		logic [15:0]             imm;
	} insn_imm_t;

	// low 11 bits of the register form
	typedef struct packed {
		logic       rsv_hi;
		logic [3:0] alu_op2;
		logic       rsv_lo;
		logic [4:0] alu_sub;
	} insn_low_t;

	// register form; stores split their offset over rd and low
	typedef struct packed {
		logic [`CTRL_OPC_W-1:0]  opcode;
		logic [`CTRL_REG_AW-1:0] rd;
		logic [`CTRL_REG_AW-1:0] ra;
		logic [`CTRL_REG_AW-1:0] rb;
		insn_low_t               low;
	} insn_reg_t;

	typedef union packed {
		insn_imm_t itype;
		insn_reg_t rtype;
	} insn_t;

	////////////////////////////////////////////////////////////////////////////
	// operation encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		BR_NOP = 3'd0,
		BR_J   = 3'd1,
		BR_JR  = 3'd2,
		BR_BF  = 3'd4,
		BR_BNF = 3'd5,
		BR_RFE = 3'd6
	} branch_op_e;

	// bit 3 marks a store
	typedef enum logic [3:0] {
		LSU_NOP = 4'b0000,
		LSU_LBZ = 4'b0010,
		LSU_LBS = 4'b0011,
		LSU_LHZ = 4'b0100,
		LSU_LHS = 4'b0101,
		LSU_LWZ = 4'b0110,
		LSU_LWS = 4'b0111,
		LSU_SB  = 4'b1010,
		LSU_SH  = 4'b1100,
		LSU_SW  = 4'b1110
	} lsu_op_e;

	// low values match the alu sub-op field
	typedef enum logic [4:0] {
		ALU_ADD   = 5'd0,
		ALU_ADDC  = 5'd1,
		ALU_SUB   = 5'd2,
		ALU_AND   = 5'd3,
		ALU_OR    = 5'd4,
		ALU_XOR   = 5'd5,
		ALU_MUL   = 5'd6,
		ALU_SHROT = 5'd8,
		ALU_DIV   = 5'd9,
		ALU_DIVU  = 5'd10,
		ALU_MULU  = 5'd11,
		ALU_EXTHB = 5'd12,
		ALU_EXTW  = 5'd13,
		ALU_CMOV  = 5'd14,
		ALU_FFL1  = 5'd15,
		ALU_MOVHI = 5'd16,
		ALU_COMP  = 5'd17,
		ALU_NOP   = 5'd31
	} alu_op_e;

	typedef enum logic [1:0] {
		RFWB_ALU  = 2'd0,
		RFWB_LR   = 2'd1,
		RFWB_SPRS = 2'd2,
		RFWB_LSU  = 2'd3
	} rfwb_src_e;

	// we sits in bit 0
	typedef struct packed {
		rfwb_src_e src;
		logic      we;
	} rfwb_op_t;

	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_e;

	// registered controls of the execute stage
	typedef struct packed {
		alu_op_e                 alu_op;
		logic [3:0]              alu_op2;
		logic [3:0]              comp_op;
		rfwb_op_t                rfwb_op;
		logic [`CTRL_REG_AW-1:0] rf_addrw;
		logic                    spr_read;
		logic                    spr_write;
		logic                    sig_syscall;
		logic                    sig_trap;
		logic                    except_illegal;
		branch_op_e              ex_branch_op;
	} ex_ctrl_t;

endpackage

// File: source/id_decode.sv
// decode stage: latches the fetched word, decodes branch, immediate and lsu op
`timescale 1ns/1ns
`include "ctrl_config.svh"

module id_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  ctrl_pkg::insn_t         if_insn,
	input  logic [`CTRL_XLEN-1:0]   id_pc,
	input  logic                    id_freeze,
	input  logic                    flush,
	output ctrl_pkg::insn_t         id_insn,
	output ctrl_pkg::branch_op_e    id_branch_op,
	output logic                    sel_imm,
	output logic [`CTRL_XLEN-1:0]   id_simm,
	output ctrl_pkg::lsu_op_e       id_lsu_op,
	output logic [31:2]             id_branch_addrtarget,
	output logic [`CTRL_REG_AW-1:0] rf_addra,
	output logic [`CTRL_REG_AW-1:0] rf_addrb,
	output logic                    rf_rda,
	output logic                    rf_rdb
);
	import ctrl_pkg::*;

	branch_op_e branch_d;
	logic       sel_imm_d;

	// register file reads start in fetch
	assign rf_addra = if_insn.itype.ra;
	assign rf_addrb = if_insn.rtype.rb;
	assign rf_rda   = if_insn[31];
	assign rf_rdb   = if_insn[30];

	////////////////////////////////////////////////////////////////////////////
	// fetch word predecode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (if_insn.itype.opcode)
			`CTRL_OPC_J, `CTRL_OPC_JAL: branch_d = BR_J;
			`CTRL_OPC_JR, `CTRL_OPC_JALR: branch_d = BR_JR;
			`CTRL_OPC_BNF: branch_d = BR_BNF;
			`CTRL_OPC_BF: branch_d = BR_BF;
			`CTRL_OPC_RFE: branch_d = BR_RFE;
			default: branch_d = BR_NOP;
		endcase
	end

	// operand b is the immediate unless the word is register form
	always_comb begin
		case (if_insn.itype.opcode)
			`CTRL_OPC_JALR, `CTRL_OPC_JR, `CTRL_OPC_RFE,
			`CTRL_OPC_MFSPR, `CTRL_OPC_MTSPR, `CTRL_OPC_XSYNC,
			`CTRL_OPC_SW, `CTRL_OPC_SB, `CTRL_OPC_SH,
			`CTRL_OPC_ALU, `CTRL_OPC_SFXX, `CTRL_OPC_NOP:
				sel_imm_d = 1'b0;
			default:
				sel_imm_d = 1'b1;
		endcase
	end

	// id latch, flush wins over freeze
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_insn      <= `CTRL_NOP_WORD;
			id_branch_op <= BR_NOP;
			sel_imm      <= 1'b0;
		end else if (flush) begin
			id_insn      <= `CTRL_NOP_WORD;
			id_branch_op <= BR_NOP;
			sel_imm      <= 1'b0;
		end else if (!id_freeze) begin
			id_insn      <= if_insn;
			id_branch_op <= branch_d;
			sel_imm      <= sel_imm_d;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// immediate extension and branch target
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (id_insn.itype.opcode)
			// arithmetic, loads and compares take a signed offset
			`CTRL_OPC_ADDI, `CTRL_OPC_ADDIC, `CTRL_OPC_XORI, `CTRL_OPC_SFXXI,
			`CTRL_OPC_LWZ, `CTRL_OPC_LWS, `CTRL_OPC_LBZ,
			`CTRL_OPC_LBS, `CTRL_OPC_LHZ, `CTRL_OPC_LHS:
				id_simm = {{16{id_insn.itype.imm[15]}}, id_insn.itype.imm};
			// store offset split across rd and low bits
			`CTRL_OPC_SW, `CTRL_OPC_SB, `CTRL_OPC_SH:
				id_simm = {{16{id_insn.rtype.rd[4]}}, id_insn.rtype.rd, id_insn.rtype.low};
			// spr number, same split, unsigned
			`CTRL_OPC_MTSPR:
				id_simm = {16'b0, id_insn.rtype.rd, id_insn.rtype.low};
			default:
				id_simm = {16'b0, id_insn.itype.imm};
		endcase
	end

	// word offset plus pc, both in word units
	assign id_branch_addrtarget = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];

	always_comb begin
		case (id_insn.itype.opcode)
			`CTRL_OPC_LWZ: id_lsu_op = LSU_LWZ;
			`CTRL_OPC_LWS: id_lsu_op = LSU_LWS;
			`CTRL_OPC_LBZ: id_lsu_op = LSU_LBZ;
			`CTRL_OPC_LBS: id_lsu_op = LSU_LBS;
			`CTRL_OPC_LHZ: id_lsu_op = LSU_LHZ;
			`CTRL_OPC_LHS: id_lsu_op = LSU_LHS;
			`CTRL_OPC_SW: id_lsu_op = LSU_SW;
			`CTRL_OPC_SB: id_lsu_op = LSU_SB;
			`CTRL_OPC_SH: id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	// flush leaves a bubble in id on the next cycle
	a_flush_nop: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> (id_insn == `CTRL_NOP_WORD) && (id_branch_op == BR_NOP));

endmodule

// File: source/ex_control.sv
// execute stage: latches the decode word and registers its execute controls
`timescale 1ns/1ns
`include "ctrl_config.svh"

module ex_control (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ctrl_pkg::insn_t      id_insn,
	input  ctrl_pkg::branch_op_e id_branch_op,
	input  logic [31:2]          id_branch_addrtarget,
	input  logic                 id_freeze,
	input  logic                 ex_freeze,
	input  logic                 flush,
	input  logic                 du_hwbkpt,
	output ctrl_pkg::insn_t      ex_insn,
	output ctrl_pkg::ex_ctrl_t   ex_ctrl,
	output logic [31:2]          ex_branch_addrtarget,
	output logic                 rfe
);
	import ctrl_pkg::*;

	// idle controls, loaded at reset and on a bubble
	localparam ex_ctrl_t EX_CTRL_NOP = '{
		alu_op: ALU_NOP,
		alu_op2: 4'd0,
		comp_op: 4'd0,
		rfwb_op: '{src: RFWB_ALU, we: 1'b0},
		rf_addrw: '0,
		spr_read: 1'b0,
		spr_write: 1'b0,
		sig_syscall: 1'b0,
		sig_trap: 1'b0,
		except_illegal: 1'b0,
		ex_branch_op: BR_NOP
	};

	ex_ctrl_t ctrl_d;
	logic     bubble;
	logic [4:0] alu_sub;

	// id held while ex moves on, or the pipe is flushed
	assign bubble  = flush | (id_freeze & ~ex_freeze);
	assign alu_sub = id_insn.rtype.low.alu_sub;

	////////////////////////////////////////////////////////////////////////////
	// execute control decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl_d = EX_CTRL_NOP;
		ctrl_d.alu_op2 = id_insn.rtype.low.alu_op2;
		// compare condition in bits 24:21
		ctrl_d.comp_op = id_insn.itype.rd[3:0];
		ctrl_d.rf_addrw = id_insn.itype.rd;
		ctrl_d.ex_branch_op = id_branch_op;
		// xsync sub-field: 000 is sys, 010 is trap
		ctrl_d.sig_syscall = (id_insn[31:23] == {`CTRL_OPC_XSYNC, 3'b000});
		ctrl_d.sig_trap = (id_insn[31:23] == {`CTRL_OPC_XSYNC, 3'b010}) | du_hwbkpt;
		case (id_insn.itype.opcode)
			`CTRL_OPC_J, `CTRL_OPC_JR, `CTRL_OPC_BNF, `CTRL_OPC_BF,
			`CTRL_OPC_RFE, `CTRL_OPC_XSYNC, `CTRL_OPC_NOP,
			`CTRL_OPC_SW, `CTRL_OPC_SB, `CTRL_OPC_SH: begin
				ctrl_d.except_illegal = 1'b0;
			end
			// return address goes to the link register
			`CTRL_OPC_JAL, `CTRL_OPC_JALR: begin
				ctrl_d.rf_addrw = `CTRL_LINK_REG;
				ctrl_d.rfwb_op = '{src: RFWB_LR, we: 1'b1};
			end
			`CTRL_OPC_MOVHI: begin
				ctrl_d.alu_op = ALU_MOVHI;
				ctrl_d.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			end
			`CTRL_OPC_MFSPR: begin
				ctrl_d.spr_read = 1'b1;
				ctrl_d.rfwb_op = '{src: RFWB_SPRS, we: 1'b1};
			end
			`CTRL_OPC_MTSPR: begin
				ctrl_d.spr_write = 1'b1;
			end
			`CTRL_OPC_LWZ, `CTRL_OPC_LWS, `CTRL_OPC_LBZ,
			`CTRL_OPC_LBS, `CTRL_OPC_LHZ, `CTRL_OPC_LHS: begin
				ctrl_d.rfwb_op = '{src: RFWB_LSU, we: 1'b1};
			end
			`CTRL_OPC_ADDI, `CTRL_OPC_ADDIC, `CTRL_OPC_ANDI,
			`CTRL_OPC_ORI, `CTRL_OPC_XORI, `CTRL_OPC_SH_ROTI: begin
				ctrl_d.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
				case (id_insn.itype.opcode)
					`CTRL_OPC_ADDI: ctrl_d.alu_op = ALU_ADD;
					`CTRL_OPC_ADDIC: ctrl_d.alu_op = ALU_ADDC;
					`CTRL_OPC_ANDI: ctrl_d.alu_op = ALU_AND;
					`CTRL_OPC_ORI: ctrl_d.alu_op = ALU_OR;
					`CTRL_OPC_XORI: ctrl_d.alu_op = ALU_XOR;
					default: ctrl_d.alu_op = ALU_SHROT;
				endcase
			end
			`CTRL_OPC_SFXX, `CTRL_OPC_SFXXI: begin
				ctrl_d.alu_op = ALU_COMP;
			end
			// register form, op comes from the low sub-op bits
			`CTRL_OPC_ALU: begin
				ctrl_d.alu_op = alu_op_e'({1'b0, alu_sub[3:0]});
				ctrl_d.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
				// no multiplier or divider in this core
				ctrl_d.except_illegal = (alu_sub == ALU_MUL) | (alu_sub == ALU_MULU) |
					(alu_sub == ALU_DIV) | (alu_sub == ALU_DIVU);
			end
			default: begin
				ctrl_d.except_illegal = 1'b1;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// ex registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_insn <= `CTRL_NOP_WORD;
			ex_ctrl <= EX_CTRL_NOP;
		end else if (bubble) begin
			ex_insn <= `CTRL_NOP_WORD;
			ex_ctrl <= EX_CTRL_NOP;
		end else if (!ex_freeze) begin
			ex_insn <= id_insn;
			ex_ctrl <= ctrl_d;
		end
	end

	// target only follows the freeze
	always_ff @(posedge clk) begin
		if (!ex_freeze)
			ex_branch_addrtarget <= id_branch_addrtarget;
	end

	// rfe seen in either stage
	assign rfe = (id_branch_op == BR_RFE) | (ex_ctrl.ex_branch_op == BR_RFE);

	a_bubble_nop: assert property (@(posedge clk) disable iff (!rst_n)
		bubble |=> (ex_insn == `CTRL_NOP_WORD) && (ex_ctrl.alu_op == ALU_NOP));

endmodule

// File: source/wb_forward.sv
// result stage that tracks the writeback word and selects operand sources with forwarding
`timescale 1ns/1ns
`include "ctrl_config.svh"

module wb_forward (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wb_freeze,
	input  logic               wbforw_valid,
	input  ctrl_pkg::insn_t    ex_insn,
	input  ctrl_pkg::insn_t    id_insn,
	input  logic               sel_imm,
	input  ctrl_pkg::ex_ctrl_t ex_ctrl,
	output ctrl_pkg::insn_t    wb_insn,
	output ctrl_pkg::sel_e     sel_a,
	output ctrl_pkg::sel_e     sel_b
);
	import ctrl_pkg::*;

	logic [`CTRL_REG_AW-1:0] wb_rfaddrw;

	// wb follows ex and ignores flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_insn    <= `CTRL_NOP_WORD;
			wb_rfaddrw <= '0;
		end else if (!wb_freeze) begin
			wb_insn    <= ex_insn;
			wb_rfaddrw <= ex_ctrl.rf_addrw;
		end
	end

	// ex result first, then wb result, else register file
	function automatic sel_e fwd_sel(input logic [`CTRL_REG_AW-1:0] addr);
		if ((addr == ex_ctrl.rf_addrw) && ex_ctrl.rfwb_op.we)
			return SEL_EX_FORW;
		else if ((addr == wb_rfaddrw) && wbforw_valid)
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	always_comb begin
		sel_a = fwd_sel(id_insn.rtype.ra);
		sel_b = sel_imm ? SEL_IMM : fwd_sel(id_insn.rtype.rb);
	end

endmodule

// File: source/ctrl_top.sv
// control path top: forms the flush and connects decode, execute and result stages
`timescale 1ns/1ns
`include "ctrl_config.svh"

module ctrl_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  ctrl_pkg::insn_t         if_insn,
	input  logic [`CTRL_XLEN-1:0]   id_pc,
	input  logic                    id_freeze,
	input  logic                    ex_freeze,
	input  logic                    wb_freeze,
	input  logic                    except_flushpipe,
	input  logic                    extend_flush,
	input  logic                    du_flush_pipe,
	input  logic                    pc_we,
	input  logic                    du_hwbkpt,
	input  logic                    wbforw_valid,
	output logic                    flush,
	output ctrl_pkg::insn_t         id_insn,
	output ctrl_pkg::branch_op_e    id_branch_op,
	output logic                    sel_imm,
	output logic [`CTRL_XLEN-1:0]   id_simm,
	output ctrl_pkg::lsu_op_e       id_lsu_op,
	output logic [31:2]             id_branch_addrtarget,
	output logic [`CTRL_REG_AW-1:0] rf_addra,
	output logic [`CTRL_REG_AW-1:0] rf_addrb,
	output logic                    rf_rda,
	output logic                    rf_rdb,
	output ctrl_pkg::insn_t         ex_insn,
	output ctrl_pkg::ex_ctrl_t      ex_ctrl,
	output logic [31:2]             ex_branch_addrtarget,
	output logic                    rfe,
	output ctrl_pkg::insn_t         wb_insn,
	output ctrl_pkg::sel_e          sel_a,
	output ctrl_pkg::sel_e          sel_b
);

	// any redirect or exception empties id and ex
	assign flush = except_flushpipe | pc_we | extend_flush | du_flush_pipe;

	////////////////////////////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////////////////////////////

	id_decode id_decode_inst (
		.clk                 (clk),
		.rst_n               (rst_n),
		.if_insn             (if_insn),
		.id_pc               (id_pc),
		.id_freeze           (id_freeze),
		.flush               (flush),
		.id_insn             (id_insn),
		.id_branch_op        (id_branch_op),
		.sel_imm             (sel_imm),
		.id_simm             (id_simm),
		.id_lsu_op           (id_lsu_op),
		.id_branch_addrtarget(id_branch_addrtarget),
		.rf_addra            (rf_addra),
		.rf_addrb            (rf_addrb),
		.rf_rda              (rf_rda),
		.rf_rdb              (rf_rdb)
	);

	ex_control ex_control_inst (
		.clk                 (clk),
		.rst_n               (rst_n),
		.id_insn             (id_insn),
		.id_branch_op        (id_branch_op),
		.id_branch_addrtarget(id_branch_addrtarget),
		.id_freeze           (id_freeze),
		.ex_freeze           (ex_freeze),
		.flush               (flush),
		.du_hwbkpt           (du_hwbkpt),
		.ex_insn             (ex_insn),
		.ex_ctrl             (ex_ctrl),
		.ex_branch_addrtarget(ex_branch_addrtarget),
		.rfe                 (rfe)
	);

	// forwarding compares the id word against ex and wb destinations
	wb_forward wb_forward_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.wb_freeze   (wb_freeze),
		.wbforw_valid(wbforw_valid),
		.ex_insn     (ex_insn),
		.id_insn     (id_insn),
		.sel_imm     (sel_imm),
		.ex_ctrl     (ex_ctrl),
		.wb_insn     (wb_insn),
		.sel_a       (sel_a),
		.sel_b       (sel_b)
	);

endmodule

// File: tb/tb_clock.sv
// free running testbench clock, 10 ns period, starts low
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// half period 5 ns
	always #5 clk = ~clk;

endmodule

// File: tb/ctrl_tb.sv
// testbench for the control path with random stimulus, a reference pipeline model and assertions
`timescale 1ns/1ns
`include "ctrl_config.svh"

module ctrl_tb;
	import ctrl_pkg::*;

	logic clk;
	logic rst_n;
	insn_t if_insn;
	logic [31:0] id_pc;
	logic id_freeze, ex_freeze, wb_freeze;
	logic except_flushpipe, extend_flush, du_flush_pipe, pc_we;
	logic du_hwbkpt, wbforw_valid;

	logic flush;
	insn_t id_insn, ex_insn, wb_insn;
	branch_op_e id_branch_op;
	logic sel_imm;
	logic [31:0] id_simm;
	lsu_op_e id_lsu_op;
	logic [31:2] id_branch_addrtarget, ex_branch_addrtarget;
	logic [4:0] rf_addra, rf_addrb;
	logic rf_rda, rf_rdb, rfe;
	ex_ctrl_t ex_ctrl;
	sel_e sel_a, sel_b;

	// reference pipeline state
	insn_t exp_id, exp_ex, exp_wb;
	branch_op_e exp_br;
	logic exp_sel_imm;
	ex_ctrl_t exp_ctrl;
	logic [4:0] exp_wb_addrw;
	logic [31:2] exp_ex_bt;
	logic [31:0] seed;
	logic flush_in;

	// opcode pool with four unknown opcodes at the end
	localparam logic [5:0] OPCS [34] = '{
		`CTRL_OPC_J, `CTRL_OPC_JAL, `CTRL_OPC_JALR, `CTRL_OPC_JR, `CTRL_OPC_BF,
		`CTRL_OPC_BNF, `CTRL_OPC_RFE, `CTRL_OPC_NOP, `CTRL_OPC_MOVHI, `CTRL_OPC_MFSPR,
		`CTRL_OPC_MTSPR, `CTRL_OPC_XSYNC, `CTRL_OPC_LWZ, `CTRL_OPC_LWS, `CTRL_OPC_LBZ,
		`CTRL_OPC_LBS, `CTRL_OPC_LHZ, `CTRL_OPC_LHS, `CTRL_OPC_ADDI, `CTRL_OPC_ADDIC,
		`CTRL_OPC_ANDI, `CTRL_OPC_ORI, `CTRL_OPC_XORI, `CTRL_OPC_SH_ROTI, `CTRL_OPC_SFXXI,
		`CTRL_OPC_SW, `CTRL_OPC_SB, `CTRL_OPC_SH, `CTRL_OPC_ALU, `CTRL_OPC_SFXX,
		6'h02, 6'h0a, 6'h1c, 6'h3f
	};

	tb_clock tb_clock_inst (.clk(clk));

	ctrl_top ctrl_top_inst (.*);

	assign flush_in = except_flushpipe | extend_flush | du_flush_pipe | pc_we;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		stop_fail($sformatf("error %s expected %h actual %h", name, exp, act));
	endtask

	function automatic branch_op_e branch_of_opcode(input logic [5:0] opc);
		if (opc == `CTRL_OPC_J || opc == `CTRL_OPC_JAL)
			return BR_J;
		if (opc == `CTRL_OPC_JR || opc == `CTRL_OPC_JALR)
			return BR_JR;
		if (opc == `CTRL_OPC_BF)
			return BR_BF;
		if (opc == `CTRL_OPC_BNF)
			return BR_BNF;
		if (opc == `CTRL_OPC_RFE)
			return BR_RFE;
		return BR_NOP;
	endfunction

	// register-form words take operand b from the register file
	function automatic logic takes_imm(input logic [5:0] opc);
		case (opc)
			`CTRL_OPC_JALR, `CTRL_OPC_JR, `CTRL_OPC_RFE, `CTRL_OPC_MFSPR,
			`CTRL_OPC_MTSPR, `CTRL_OPC_XSYNC, `CTRL_OPC_SW, `CTRL_OPC_SB,
			`CTRL_OPC_SH, `CTRL_OPC_ALU, `CTRL_OPC_SFXX, `CTRL_OPC_NOP:
				return 1'b0;
			default:
				return 1'b1;
		endcase
	endfunction

	function automatic lsu_op_e lsu_of_opcode(input logic [5:0] opc);
		case (opc)
			`CTRL_OPC_LWZ: return LSU_LWZ;
			`CTRL_OPC_LWS: return LSU_LWS;
			`CTRL_OPC_LBZ: return LSU_LBZ;
			`CTRL_OPC_LBS: return LSU_LBS;
			`CTRL_OPC_LHZ: return LSU_LHZ;
			`CTRL_OPC_LHS: return LSU_LHS;
			`CTRL_OPC_SW: return LSU_SW;
			`CTRL_OPC_SB: return LSU_SB;
			`CTRL_OPC_SH: return LSU_SH;
			default: return LSU_NOP;
		endcase
	endfunction

	function automatic ex_ctrl_t idle_ctrl();
		ex_ctrl_t c;
		c = '0;
		c.alu_op = ALU_NOP;
		c.ex_branch_op = BR_NOP;
		return c;
	endfunction

	function automatic ex_ctrl_t execute_controls(input logic [31:0] w, input branch_op_e br,
			input logic hw);
		ex_ctrl_t c;
		logic [4:0] sub;
		c = idle_ctrl();
		sub = w[4:0];
		c.alu_op2 = w[9:6];
		c.comp_op = w[24:21];
		c.rf_addrw = w[25:21];
		c.ex_branch_op = br;
		c.sig_syscall = (w[31:26] == `CTRL_OPC_XSYNC) && (w[25:23] == 3'b000);
		c.sig_trap = ((w[31:26] == `CTRL_OPC_XSYNC) && (w[25:23] == 3'b010)) || hw;
		case (w[31:26])
			`CTRL_OPC_J, `CTRL_OPC_JR, `CTRL_OPC_BNF, `CTRL_OPC_BF, `CTRL_OPC_RFE,
			`CTRL_OPC_XSYNC, `CTRL_OPC_NOP, `CTRL_OPC_SW, `CTRL_OPC_SB, `CTRL_OPC_SH:
				c.except_illegal = 1'b0;
			`CTRL_OPC_JAL, `CTRL_OPC_JALR: begin
				c.rf_addrw = `CTRL_LINK_REG;
				c.rfwb_op = '{src: RFWB_LR, we: 1'b1};
			end
			`CTRL_OPC_MFSPR: begin
				c.spr_read = 1'b1;
				c.rfwb_op = '{src: RFWB_SPRS, we: 1'b1};
			end
			`CTRL_OPC_MTSPR:
				c.spr_write = 1'b1;
			`CTRL_OPC_LWZ, `CTRL_OPC_LWS, `CTRL_OPC_LBZ,
			`CTRL_OPC_LBS, `CTRL_OPC_LHZ, `CTRL_OPC_LHS:
				c.rfwb_op = '{src: RFWB_LSU, we: 1'b1};
			`CTRL_OPC_SFXX, `CTRL_OPC_SFXXI:
				c.alu_op = ALU_COMP;
			`CTRL_OPC_MOVHI, `CTRL_OPC_ADDI, `CTRL_OPC_ADDIC, `CTRL_OPC_ANDI,
			`CTRL_OPC_ORI, `CTRL_OPC_XORI, `CTRL_OPC_SH_ROTI: begin
				c.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
				case (w[31:26])
					`CTRL_OPC_MOVHI: c.alu_op = ALU_MOVHI;
					`CTRL_OPC_ADDI: c.alu_op = ALU_ADD;
					`CTRL_OPC_ADDIC: c.alu_op = ALU_ADDC;
					`CTRL_OPC_ANDI: c.alu_op = ALU_AND;
					`CTRL_OPC_ORI: c.alu_op = ALU_OR;
					`CTRL_OPC_XORI: c.alu_op = ALU_XOR;
					default: c.alu_op = ALU_SHROT;
				endcase
			end
			`CTRL_OPC_ALU: begin
				c.alu_op = alu_op_e'({1'b0, sub[3:0]});
				c.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
				// multiply and divide sub-ops are not built
				c.except_illegal = (sub == 5'd6) || (sub == 5'd9) ||
					(sub == 5'd10) || (sub == 5'd11);
			end
			default:
				c.except_illegal = 1'b1;
		endcase
		return c;
	endfunction

	function automatic logic [31:0] extended_imm(input logic [31:0] w);
		case (w[31:26])
			`CTRL_OPC_ADDI, `CTRL_OPC_ADDIC, `CTRL_OPC_XORI, `CTRL_OPC_SFXXI,
			`CTRL_OPC_LWZ, `CTRL_OPC_LWS, `CTRL_OPC_LBZ,
			`CTRL_OPC_LBS, `CTRL_OPC_LHZ, `CTRL_OPC_LHS:
				return {{16{w[15]}}, w[15:0]};
			`CTRL_OPC_SW, `CTRL_OPC_SB, `CTRL_OPC_SH:
				return {{16{w[25]}}, w[25:21], w[10:0]};
			`CTRL_OPC_MTSPR:
				return {16'b0, w[25:21], w[10:0]};
			default:
				return {16'b0, w[15:0]};
		endcase
	endfunction

	function automatic logic [31:2] target_addr(input logic [31:0] w, input logic [31:0] pc);
		return {{4{w[25]}}, w[25:0]} + pc[31:2];
	endfunction

	function automatic sel_e operand_sel(input logic [4:0] addr);
		if (addr == exp_ctrl.rf_addrw && exp_ctrl.rfwb_op.we)
			return SEL_EX_FORW;
		if (addr == exp_wb_addrw && wbforw_valid)
			return SEL_WB_FORW;
		return SEL_RF;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_id <= `CTRL_NOP_WORD;
			exp_br <= BR_NOP;
			exp_sel_imm <= 1'b0;
			exp_ex <= `CTRL_NOP_WORD;
			exp_ctrl <= idle_ctrl();
			exp_wb <= `CTRL_NOP_WORD;
			exp_wb_addrw <= '0;
		end else begin
			if (flush_in) begin
				exp_id <= `CTRL_NOP_WORD;
				exp_br <= BR_NOP;
				exp_sel_imm <= 1'b0;
			end else if (!id_freeze) begin
				exp_id <= if_insn;
				exp_br <= branch_of_opcode(if_insn[31:26]);
				exp_sel_imm <= takes_imm(if_insn[31:26]);
			end
			// bubble into ex
			if (flush_in || (id_freeze && !ex_freeze)) begin
				exp_ex <= `CTRL_NOP_WORD;
				exp_ctrl <= idle_ctrl();
			end else if (!ex_freeze) begin
				exp_ex <= exp_id;
				exp_ctrl <= execute_controls(exp_id, exp_br, du_hwbkpt);
			end
			if (!wb_freeze) begin
				exp_wb <= exp_ex;
				exp_wb_addrw <= exp_ctrl.rf_addrw;
			end
		end
	end

	always @(posedge clk) begin
		if (!ex_freeze)
			exp_ex_bt <= target_addr(exp_id, id_pc);
	end

	////////////////////////////////////////////////////////////////////////////
	// checks sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////

	a_reset: assert property (@(negedge clk) !rst_n |-> (id_insn == `CTRL_NOP_WORD &&
		ex_insn == `CTRL_NOP_WORD && wb_insn == `CTRL_NOP_WORD && !sel_imm &&
		id_branch_op == BR_NOP && ex_ctrl == idle_ctrl()))
		else stop_fail("outputs not idle while reset is held");
	a_flush: assert property (@(negedge clk) flush == flush_in)
		else report_mismatch("flush", flush_in, flush);
	a_id: assert property (@(negedge clk) disable iff (!rst_n) id_insn == exp_id)
		else report_mismatch("id_insn", exp_id, id_insn);
	a_ex: assert property (@(negedge clk) disable iff (!rst_n) ex_insn == exp_ex)
		else report_mismatch("ex_insn", exp_ex, ex_insn);
	a_wb: assert property (@(negedge clk) disable iff (!rst_n) wb_insn == exp_wb)
		else report_mismatch("wb_insn", exp_wb, wb_insn);
	a_br: assert property (@(negedge clk) disable iff (!rst_n) id_branch_op == exp_br)
		else report_mismatch("id_branch_op", exp_br, id_branch_op);
	a_imm: assert property (@(negedge clk) disable iff (!rst_n) sel_imm == exp_sel_imm)
		else report_mismatch("sel_imm", exp_sel_imm, sel_imm);
	a_ctrl: assert property (@(negedge clk) disable iff (!rst_n) ex_ctrl == exp_ctrl)
		else report_mismatch("ex_ctrl", exp_ctrl, ex_ctrl);
	a_simm: assert property (@(negedge clk) disable iff (!rst_n)
		id_simm == extended_imm(exp_id))
		else report_mismatch("id_simm", extended_imm(exp_id), id_simm);
	a_lsu: assert property (@(negedge clk) disable iff (!rst_n)
		id_lsu_op == lsu_of_opcode(exp_id[31:26]))
		else report_mismatch("id_lsu_op", lsu_of_opcode(exp_id[31:26]), id_lsu_op);
	// read ports follow the fetched word
	a_rf_addr: assert property (@(negedge clk) disable iff (!rst_n)
		rf_addra == if_insn[20:16] && rf_addrb == if_insn[15:11])
		else report_mismatch("rf_addr", {if_insn[20:16], if_insn[15:11]}, {rf_addra, rf_addrb});
	a_rf_rd: assert property (@(negedge clk) disable iff (!rst_n)
		rf_rda == if_insn[31] && rf_rdb == if_insn[30])
		else report_mismatch("rf_rd", {if_insn[31], if_insn[30]}, {rf_rda, rf_rdb});
	a_target: assert property (@(negedge clk) disable iff (!rst_n)
		id_branch_addrtarget == target_addr(exp_id, id_pc))
		else report_mismatch("id_target", target_addr(exp_id, id_pc), id_branch_addrtarget);
	a_ex_target: assert property (@(negedge clk) disable iff (!rst_n)
		ex_branch_addrtarget == exp_ex_bt)
		else report_mismatch("ex_target", exp_ex_bt, ex_branch_addrtarget);
	a_rfe: assert property (@(negedge clk) disable iff (!rst_n)
		rfe == (exp_br == BR_RFE || exp_ctrl.ex_branch_op == BR_RFE))
		else report_mismatch("rfe", !rfe, rfe);
	a_sel_a: assert property (@(negedge clk) disable iff (!rst_n)
		sel_a == operand_sel(exp_id[20:16]))
		else report_mismatch("sel_a", operand_sel(exp_id[20:16]), sel_a);
	a_sel_b: assert property (@(negedge clk) disable iff (!rst_n)
		sel_b == (exp_sel_imm ? SEL_IMM : operand_sel(exp_id[15:11])))
		else report_mismatch("sel_b", exp_sel_imm ? SEL_IMM : operand_sel(exp_id[15:11]),
			sel_b);

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [31:0] w;
		int n;
		int idx;
		seed = 32'h20a;
		rst_n = 1'b0;
		if_insn = `CTRL_NOP_WORD;
		id_pc = '0;
		{id_freeze, ex_freeze, wb_freeze} = '0;
		{except_flushpipe, extend_flush, du_flush_pipe, pc_we} = '0;
		du_hwbkpt = 1'b0;
		wbforw_valid = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// one tagged word through an idle pipe
		@(posedge clk);
		if_insn <= {`CTRL_OPC_ADDI, 26'h2a5_1234};
		@(posedge clk);
		if_insn <= `CTRL_NOP_WORD;
		// edges counted from the one that drove the word
		n = 1;
		@(negedge clk);
		while (wb_insn != {`CTRL_OPC_ADDI, 26'h2a5_1234}) begin
			@(negedge clk);
			n++;
			if (n > 10)
				stop_fail("timeout waiting for the tagged word in writeback");
		end
		assert (n == 3) else report_mismatch("travel_edges", 3, n);

		// random words with freeze, flush, breakpoint and forwarding traffic
		for (int i = 0; i < 600; i++) begin
			@(posedge clk);
			r = next_rand();
			w = next_rand();
			idx = int'(r[15:0]) % 34;
			// narrow register fields half the time so addresses collide
			if (i % 2 == 0)
				w[25:11] = w[25:11] & 15'b00011_00011_00011;
			if_insn <= {OPCS[idx], w[25:0]};
			id_pc <= next_rand();
			id_freeze <= (r[31:29] == 3'd0);
			ex_freeze <= (r[28:26] == 3'd0);
			wb_freeze <= (r[25:23] == 3'd0);
			except_flushpipe <= (r[22:20] == 3'd0) && (r[19:18] == 2'd0);
			extend_flush <= (r[22:20] == 3'd0) && (r[19:18] == 2'd1);
			du_flush_pipe <= (r[22:20] == 3'd0) && (r[19:18] == 2'd2);
			pc_we <= (r[22:20] == 3'd0) && (r[19:18] == 2'd3);
			du_hwbkpt <= (w[31:29] == 3'd0);
			wbforw_valid <= w[28];
		end
		@(posedge clk);
		{id_freeze, ex_freeze, wb_freeze} <= '0;
		{except_flushpipe, extend_flush, du_flush_pipe, pc_we} <= '0;
		repeat (4) @(posedge clk);
		$display("All tests passed");
		$finish;
	end

endmodule

// File: src.f
+incdir+include
source/ctrl_pkg.sv
source/id_decode.sv
source/ex_control.sv
source/wb_forward.sv
source/ctrl_top.sv
tb/tb_clock.sv
tb/ctrl_tb.sv

// File: run.sh
#!/bin/bash
# builds the control path testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module ctrl_tb -o ctrl_sim

./obj_dir/ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
	exit 0
else
	exit 1
fi
